//--- list.f
+incdir+test
common/core_pkg.sv
common/rf_dbg_if.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/int_regfile.sv
rtl/debug_unit.sv
rtl/core_top.sv
test/tb_core.sv

//--- Makefile
# Verilator build and run for the RV32 core testbench

VERILATOR  ?= verilator
TB_TOP     ?= tb_core
RTL_TOP    ?= core_top
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: run build lint clean

run: build
	./$(OBJ_DIR)/V$(TB_TOP)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_core_model.svh
`ifndef TB_CORE_MODEL_SVH
`define TB_CORE_MODEL_SVH

////////////////////////////////////////
// Reference model of the kept ISA
////////////////////////////////////////
word_t model_regs [32];
int    model_done;     // Instructions retired by the model

function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                  input word_t a, input word_t b);
  logic signed [31:0] sa;
  sa = a;
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << b[4:0];
    3'b010:  return word_t'($signed(a) < $signed(b));
    3'b011:  return word_t'(a < b);
    3'b100:  return a ^ b;
    3'b101:  return alt ? word_t'(sa >>> b[4:0]) : a >> b[4:0];
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

// Anything undefined leaves the registers alone
function automatic void model_exec(input word_t insn);
  word_t      a;
  word_t      r;
  logic       ok;
  logic [6:0] f7;
  logic [2:0] f3;
  reg_idx_t   rd;
  rd = insn[11:7];
  f3 = insn[14:12];
  f7 = insn[31:25];
  a  = model_regs[insn[19:15]];
  ok = 1'b0;
  r  = '0;
  case (insn[6:0])
    OPC_OP:
      if (f7 == 7'b0000000 || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101)))
      begin
        ok = 1'b1;
        r  = ref_alu(f3, f7[5], a, model_regs[insn[24:20]]);
      end
    OPC_OP_IMM:
    begin
      if (f3 == 3'b001)
        ok = (f7 == 7'b0000000);
      else if (f3 == 3'b101)
        ok = (f7 == 7'b0000000) || (f7 == 7'b0100000);
      else
        ok = 1'b1;
      r = ref_alu(f3, (f3 == 3'b101) && f7[5], a, {{20{insn[31]}}, insn[31:20]});
    end
    OPC_LUI:
    begin
      ok = 1'b1;
      r  = {insn[31:12], 12'h000};
    end
    default: ok = 1'b0;
  endcase
  if (ok && rd != '0)
    model_regs[rd] = r;
endfunction

function automatic void model_run(input int upto);
  while (model_done < upto)
  begin
    model_exec(prog_word(model_done));
    model_done++;
  end
endfunction

////////////////////////////////////////
// Random program
////////////////////////////////////////
function automatic reg_idx_t pick_reg();
  if ($urandom_range(0, 9) < 8)
    return reg_idx_t'($urandom_range(0, 5));   // Small pool, lots of reuse
  return reg_idx_t'($urandom_range(0, 31));
endfunction

function automatic word_t gen_insn();
  reg_idx_t    rd;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [11:0] imm;
  word_t       insn;
  rd  = pick_reg();
  rs1 = pick_reg();
  rs2 = pick_reg();
  f3  = 3'($urandom_range(0, 7));
  f7  = 7'b0000000;
  imm = 12'($urandom());
  case ($urandom_range(0, 9))
    0, 1, 2, 3:
    begin
      if ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(0, 1) == 1)
        f7 = 7'b0100000;   // SUB or SRA
      insn = {f7, rs2, rs1, f3, rd, OPC_OP};
    end
    4, 5, 6:
    begin
      if (f3 == 3'b001)
        imm[11:5] = 7'b0000000;
      else if (f3 == 3'b101)
        imm[11:5] = ($urandom_range(0, 1) == 1) ? 7'b0100000 : 7'b0000000;
      insn = {imm, rs1, f3, rd, OPC_OP_IMM};
    end
    7: insn = {20'($urandom()), rd, OPC_LUI};
    8:
      case ($urandom_range(0, 2))
        0:       insn = {7'b0000001, rs2, rs1, f3, rd, OPC_OP};        // M extension
        1:       insn = {7'b0100000, rs2, rs1, 3'b001, rd, OPC_OP_IMM}; // Bad shift
        default: insn = {25'($urandom()), 7'b1100011};                  // Branch
      endcase
    default: insn = {imm, rs1, 3'b000, 5'd0, OPC_OP_IMM};   // Aimed at x0
  endcase
  return insn;
endfunction

////////////////////////////////////////
// Compare tasks
////////////////////////////////////////
task automatic check_word(input string name, input word_t got, input word_t exp);
  if (got !== exp)
    fail_run($sformatf("error: %s is %h, expected %h", name, got, exp));
endtask

// Fetch addresses
task automatic check_idx(input string name, input word_t got, input word_t exp);
  if (got !== exp)
    fail_run($sformatf("error: %s address is %h, expected %h", name, got, exp));
endtask

`endif

//--- test/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core
  import core_pkg::*;
();

  localparam word_t PC_INIT         = 32'h200;
  localparam int    SEED            = 32'h396e;
  localparam int    PROG_DEPTH      = 128;
  localparam int    RUN1            = 48;     // Fetches before the first halt
  localparam int    RUN2            = 104;
  localparam int    DBG_OPS         = 110;    // Debug accesses over the whole run
  localparam int    WATCHDOG_CYCLES = RUN2 * 8 + DBG_OPS * 8;

  logic                     clk_i;
  logic                     rst_n_i;
  word_t                    imem_adr_o;
  logic                     imem_req_o;
  logic                     imem_ack_i;
  word_t                    imem_insn_i;
  logic                     dbg_stall_i;
  logic                     dbg_strb_i;
  logic                     dbg_we_i;
  logic [DBG_ADDR_SIZE-1:0] dbg_addr_i;
  word_t                    dbg_dati_i;
  word_t                    dbg_dato_o;
  logic                     dbg_ack_o;

  word_t prog [PROG_DEPTH];
  int    fetch_cnt;     // Acknowledged fetches
  int    wait_cnt;
  logic  core_halted;

  function automatic word_t prog_word(input int idx);
    if (idx < PROG_DEPTH)
      return prog[idx];
    return NOP_INSN;
  endfunction

  `include "tb_core_model.svh"

  core_top #(
    .PC_INIT     ( PC_INIT     ) )
  u_core_top (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .imem_adr_o  ( imem_adr_o  ),
    .imem_req_o  ( imem_req_o  ),
    .imem_ack_i  ( imem_ack_i  ),
    .imem_insn_i ( imem_insn_i ),
    .dbg_stall_i ( dbg_stall_i ),
    .dbg_strb_i  ( dbg_strb_i  ),
    .dbg_we_i    ( dbg_we_i    ),
    .dbg_addr_i  ( dbg_addr_i  ),
    .dbg_dati_i  ( dbg_dati_i  ),
    .dbg_dato_o  ( dbg_dato_o  ),
    .dbg_ack_o   ( dbg_ack_o   ) );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  ////////////////////////////////////////
  // Instruction memory
  ////////////////////////////////////////
  always @(posedge clk_i)
  begin : imem_responder
    int taken;
    taken = fetch_cnt;
    if (!rst_n_i)
    begin
      imem_ack_i <= 1'b0;
      wait_cnt   = 0;
    end
    else
    begin
      if (imem_req_o)
      begin
        check_idx("imem_adr_o", imem_adr_o, PC_INIT + word_t'(4 * fetch_cnt));
        if (core_halted)
          fail_run("imem_req_o was raised while the core is halted");
      end
      if (imem_req_o && imem_ack_i)
      begin
        taken    = fetch_cnt + 1;
        wait_cnt = $urandom_range(0, 3);   // Gap before the next ack
      end
      if (wait_cnt == 0)
      begin
        imem_ack_i  <= 1'b1;
        imem_insn_i <= prog_word(taken);
      end
      else
      begin
        imem_ack_i <= 1'b0;
        wait_cnt   = wait_cnt - 1;
      end
    end
    fetch_cnt <= taken;
  end

  always @(posedge clk_i)
  begin
    if (rst_n_i && dbg_ack_o && !dbg_strb_i)
      fail_run("dbg_ack_o pulsed with no strobe pending");
  end

  ////////////////////////////////////////
  // Debug host
  ////////////////////////////////////////
  task automatic dbg_access(input logic we, input logic [DBG_ADDR_SIZE-1:0] addr,
                            input word_t wdata, output word_t rdata);
    @(posedge clk_i);
    dbg_strb_i <= 1'b1;
    dbg_we_i   <= we;
    dbg_addr_i <= addr;
    dbg_dati_i <= wdata;
    do
      @(posedge clk_i);
    while (!dbg_ack_o);
    rdata      = dbg_dato_o;
    dbg_strb_i <= 1'b0;
    dbg_we_i   <= 1'b0;
    @(posedge clk_i);
    if (dbg_ack_o)
      fail_run("dbg_ack_o stayed high for a second cycle");
  endtask

  // Stall, wait for the first ack, then dump PC and all registers
  task automatic halt_and_dump();
    word_t val;
    @(posedge clk_i);
    dbg_stall_i <= 1'b1;
    dbg_access(1'b0, DBG_PC_ADDR, '0, val);
    core_halted <= 1'b1;
    model_run(fetch_cnt);
    check_word("dbg_dato_o (pc)", val, PC_INIT + word_t'(4 * fetch_cnt));
    for (int i = 0; i < 32; i++)
    begin
      dbg_access(1'b0, 6'(i), '0, val);
      check_word($sformatf("dbg_dato_o (x%0d)", i), val, model_regs[i]);
    end
  endtask

  initial
  begin : stimulus
    word_t val;
    word_t wval;
    rst_n_i     = 1'b0;
    imem_ack_i  = 1'b0;
    imem_insn_i = NOP_INSN;
    dbg_stall_i = 1'b0;
    dbg_strb_i  = 1'b0;
    dbg_we_i    = 1'b0;
    dbg_addr_i  = '0;
    dbg_dati_i  = '0;
    fetch_cnt   = 0;
    wait_cnt    = 0;
    core_halted = 1'b0;
    model_done  = 0;
    for (int i = 0; i < 32; i++)
      model_regs[i] = '0;
    void'($urandom(SEED));
    for (int i = 0; i < PROG_DEPTH; i++)
      prog[i] = gen_insn();

    repeat (2) @(posedge clk_i);
    if (imem_req_o || dbg_ack_o)
      fail_run("imem_req_o or dbg_ack_o was high during reset");
    rst_n_i <= 1'b1;

    while (fetch_cnt < RUN1)
      @(posedge clk_i);
    halt_and_dump();

    // x0 and the PC ignore debug writes
    dbg_access(1'b1, 6'd0, 32'hdead_beef, val);
    dbg_access(1'b0, 6'd0, '0, val);
    check_word("dbg_dato_o (x0)", val, '0);
    dbg_access(1'b1, DBG_PC_ADDR, 32'h1234_5678, val);

    for (int i = 1; i < 32; i++)
    begin
      wval = $urandom();
      dbg_access(1'b1, 6'(i), wval, val);
      model_regs[i] = wval;
    end
    dbg_access(1'b0, 6'd1, '0, val);
    check_word("dbg_dato_o (x1)", val, model_regs[1]);

    @(posedge clk_i);
    dbg_stall_i <= 1'b0;   // Resume with the new register values
    core_halted <= 1'b0;
    while (fetch_cnt < RUN2)
      @(posedge clk_i);
    halt_and_dump();

    $display("*** PASSED ***");
    $finish;
  end

  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    fail_run("timeout, the run did not finish within its cycle budget");
  end

endmodule

`default_nettype wire

//--- rtl/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top
  import core_pkg::*;
#(
  parameter word_t PC_INIT = 'h200
)
(
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,

  // Instruction memory
  output word_t                         imem_adr_o,
  output logic                          imem_req_o,
  input  wire logic                     imem_ack_i,
  input  wire word_t                    imem_insn_i,

  // Debug
  input  wire logic                     dbg_stall_i,
  input  wire logic                     dbg_strb_i,
  input  wire logic                     dbg_we_i,
  input  wire logic [DBG_ADDR_SIZE-1:0] dbg_addr_i,
  input  wire word_t                    dbg_dati_i,
  output word_t                         dbg_dato_o,
  output logic                          dbg_ack_o
);

  logic     du_stall;
  word_t    fetch_pc;

  logic     if_valid;
  word_t    if_insn;

  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  word_t    rf_rs1;
  word_t    rf_rs2;

  logic     id_valid;
  decoded_t id_dec;
  word_t    id_op_a;
  word_t    id_op_b;

  logic     ex_valid;
  logic     ex_we;
  reg_idx_t ex_rd;
  word_t    ex_result;

  rf_dbg_if u_rf_dbg ();

  fetch_stage #(
    .PC_INIT     ( PC_INIT     ) )
  u_fetch (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .du_stall_i  ( du_stall    ),
    .imem_adr_o  ( imem_adr_o  ),
    .imem_req_o  ( imem_req_o  ),
    .imem_ack_i  ( imem_ack_i  ),
    .imem_insn_i ( imem_insn_i ),
    .if_valid_o  ( if_valid    ),
    .if_pc_o     (             ),
    .if_insn_o   ( if_insn     ),
    .pc_o        ( fetch_pc    ) );

  // Execute register feeds both bypass levels and the write port
  decode_stage u_decode (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .if_valid_i  ( if_valid    ),
    .if_insn_i   ( if_insn     ),
    .rs1_idx_o   ( rs1_idx     ),
    .rs2_idx_o   ( rs2_idx     ),
    .rf_rs1_i    ( rf_rs1      ),
    .rf_rs2_i    ( rf_rs2      ),
    .ex_valid_i  ( ex_valid    ),
    .ex_rd_i     ( ex_rd       ),
    .ex_we_i     ( ex_we       ),
    .ex_result_i ( ex_result   ),
    .wb_valid_i  ( ex_valid    ),
    .wb_rd_i     ( ex_rd       ),
    .wb_we_i     ( ex_we       ),
    .wb_result_i ( ex_result   ),
    .id_valid_o  ( id_valid    ),
    .id_dec_o    ( id_dec      ),
    .id_op_a_o   ( id_op_a     ),
    .id_op_b_o   ( id_op_b     ) );

  execute_stage u_execute (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .id_valid_i  ( id_valid    ),
    .id_dec_i    ( id_dec      ),
    .id_op_a_i   ( id_op_a     ),
    .id_op_b_i   ( id_op_b     ),
    .ex_valid_o  ( ex_valid    ),
    .ex_we_o     ( ex_we       ),
    .ex_rd_o     ( ex_rd       ),
    .ex_result_o ( ex_result   ) );

  int_regfile u_regfile (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .rs1_idx_i   ( rs1_idx     ),
    .rs2_idx_i   ( rs2_idx     ),
    .rs1_o       ( rf_rs1      ),
    .rs2_o       ( rf_rs2      ),
    .wr_en_i     ( ex_we       ),
    .wr_idx_i    ( ex_rd       ),
    .wr_data_i   ( ex_result   ),
    .dbg         ( u_rf_dbg.rf ) );

  debug_unit u_debug (
    .clk_i       ( clk_i                                        ),
    .rst_n_i     ( rst_n_i                                      ),
    .dbg_stall_i ( dbg_stall_i                                  ),
    .dbg_strb_i  ( dbg_strb_i                                   ),
    .dbg_we_i    ( dbg_we_i                                     ),
    .dbg_addr_i  ( dbg_addr_i                                   ),
    .dbg_dati_i  ( dbg_dati_i                                   ),
    .dbg_dato_o  ( dbg_dato_o                                   ),
    .dbg_ack_o   ( dbg_ack_o                                    ),
    .pipe_busy_i ( if_valid | id_valid | ex_valid | imem_req_o  ),
    .pc_i        ( fetch_pc                                     ),
    .du_stall_o  ( du_stall                                     ),
    .rf          ( u_rf_dbg.du                                  ) );

endmodule

`default_nettype wire

//--- rtl/debug_unit.sv
`timescale 1ns/1ps
`default_nettype none

module debug_unit
  import core_pkg::*;
(
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,

  input  wire logic                     dbg_stall_i,
  input  wire logic                     dbg_strb_i,
  input  wire logic                     dbg_we_i,
  input  wire logic [DBG_ADDR_SIZE-1:0] dbg_addr_i,
  input  wire word_t                    dbg_dati_i,
  output word_t                         dbg_dato_o,
  output logic                          dbg_ack_o,

  input  wire logic                     pipe_busy_i,
  input  wire word_t                    pc_i,
  output logic                          du_stall_o,

  rf_dbg_if.du                          rf
);

  logic  stall_q;
  logic  halted_q;
  logic  ack_q;
  word_t dato_q;
  logic  access;
  logic  sel_pc;
  logic  sel_rf;

  ////////////////////////////////////////
  // Stall and halt
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      stall_q  <= 1'b1;    // Fetch held until the first edge
      halted_q <= 1'b0;
      ack_q    <= 1'b0;
    end
    else
    begin
      stall_q  <= dbg_stall_i;
      halted_q <= dbg_stall_i && stall_q && !pipe_busy_i;  // Nothing left in flight
      ack_q    <= access;
    end
  end

  assign du_stall_o = stall_q;

  ////////////////////////////////////////
  // Debug bus
  ////////////////////////////////////////

  // Strobe is still high in the ack cycle
  assign access = halted_q && dbg_strb_i && !ack_q;
  assign sel_pc = dbg_addr_i == DBG_PC_ADDR;
  assign sel_rf = !dbg_addr_i[DBG_ADDR_SIZE-1];   // x0..x31

  assign rf.addr  = dbg_addr_i[4:0];
  assign rf.we    = access && dbg_we_i && sel_rf; // PC writes dropped
  assign rf.wdata = dbg_dati_i;

  always_ff @(posedge clk_i)
  begin
    if (access)
      dato_q <= sel_pc ? pc_i : (sel_rf ? rf.rdata : '0);
  end

  assign dbg_dato_o = dato_q;
  assign dbg_ack_o  = ack_q;

  a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dbg_ack_o |=> !dbg_ack_o);

endmodule

`default_nettype wire

//--- rtl/int_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module int_regfile
  import core_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_n_i,

  input  wire reg_idx_t rs1_idx_i,
  input  wire reg_idx_t rs2_idx_i,
  output word_t         rs1_o,
  output word_t         rs2_o,

  input  wire logic     wr_en_i,
  input  wire reg_idx_t wr_idx_i,
  input  wire word_t    wr_data_i,

  rf_dbg_if.rf          dbg
);

  word_t regs [1:31];   // x0 has no storage

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end
    else
    begin
      if (wr_en_i && (wr_idx_i != '0))
        regs[wr_idx_i] <= wr_data_i;      // Pipeline write-back
      if (dbg.we && (dbg.addr != '0))
        regs[dbg.addr] <= dbg.wdata;      // Debug, only while halted
    end
  end

  assign rs1_o     = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
  assign rs2_o     = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];
  assign dbg.rdata = (dbg.addr == '0) ? '0 : regs[dbg.addr];

  // Debug unit writes only once the pipeline has drained
  a_one_writer: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(wr_en_i && dbg.we));

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage
  import core_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_n_i,

  input  wire logic     id_valid_i,
  input  wire decoded_t id_dec_i,
  input  wire word_t    id_op_a_i,
  input  wire word_t    id_op_b_i,

  output logic          ex_valid_o,
  output logic          ex_we_o,
  output reg_idx_t      ex_rd_o,
  output word_t         ex_result_o
);

  word_t      op_b;
  logic [4:0] shamt;
  word_t      alu_r;
  logic       valid_q;
  logic       we_q;
  reg_idx_t   rd_q;
  word_t      result_q;

  assign op_b  = id_dec_i.use_imm ? id_dec_i.imm : id_op_b_i;
  assign shamt = op_b[4:0];   // RV32 shift amount

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////
  always_comb
  begin
    case (id_dec_i.alu_op)
      ALU_ADD:    alu_r = id_op_a_i + op_b;
      ALU_SUB:    alu_r = id_op_a_i - op_b;
      ALU_SLL:    alu_r = id_op_a_i << shamt;
      ALU_SLT:    alu_r = {{(XLEN-1){1'b0}}, $signed(id_op_a_i) < $signed(op_b)};
      ALU_SLTU:   alu_r = {{(XLEN-1){1'b0}}, id_op_a_i < op_b};
      ALU_XOR:    alu_r = id_op_a_i ^ op_b;
      ALU_SRL:    alu_r = id_op_a_i >> shamt;
      ALU_SRA:    alu_r = word_t'($signed(id_op_a_i) >>> shamt);
      ALU_OR:     alu_r = id_op_a_i | op_b;
      ALU_AND:    alu_r = id_op_a_i & op_b;
      ALU_PASS_B: alu_r = op_b;
      default:    alu_r = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      valid_q <= 1'b0;
      we_q    <= 1'b0;
    end
    else
    begin
      valid_q <= id_valid_i;
      we_q    <= id_valid_i && id_dec_i.rd_we;  // Bubbles never write
    end
  end

  always_ff @(posedge clk_i)
  begin
    rd_q     <= id_dec_i.rd;
    result_q <= alu_r;
  end

  // Register file writes from here at the next edge
  assign ex_valid_o  = valid_q;
  assign ex_we_o     = we_q;
  assign ex_rd_o     = rd_q;
  assign ex_result_o = result_q;

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
  import core_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_n_i,

  input  wire logic     if_valid_i,
  input  wire word_t    if_insn_i,

  output reg_idx_t      rs1_idx_o,
  output reg_idx_t      rs2_idx_o,
  input  wire word_t    rf_rs1_i,
  input  wire word_t    rf_rs2_i,

  input  wire logic     ex_valid_i,
  input  wire reg_idx_t ex_rd_i,
  input  wire logic     ex_we_i,
  input  wire word_t    ex_result_i,
  input  wire logic     wb_valid_i,
  input  wire reg_idx_t wb_rd_i,
  input  wire logic     wb_we_i,
  input  wire word_t    wb_result_i,

  output logic          id_valid_o,
  output decoded_t      id_dec_o,
  output word_t         id_op_a_o,
  output word_t         id_op_b_o
);

  word_t      insn;
  logic [6:0] funct7;
  logic [2:0] funct3;
  logic       legal;
  decoded_t   dec;
  decoded_t   dec_q;
  logic       valid_q;
  word_t      op_a_q;
  word_t      op_b_q;

  // Take a result in flight when it targets idx, x0 never forwards
  function automatic word_t fwd(input reg_idx_t idx, input word_t dflt,
                                input logic v, input logic we,
                                input reg_idx_t rd, input word_t res);
    if (v && we && (rd == idx) && (idx != '0))
      return res;
    return dflt;
  endfunction

  assign insn   = if_valid_i ? if_insn_i : NOP_INSN;  // Bubble decodes as NOP
  assign funct7 = insn[31:25];
  assign funct3 = insn[14:12];

  assign rs1_idx_o = insn[19:15];
  assign rs2_idx_o = insn[24:20];

  ////////////////////////////////////////
  // Instruction decode
  ////////////////////////////////////////
  always_comb
  begin
    dec        = '0;
    dec.alu_op = ALU_ADD;
    dec.rd     = insn[11:7];
    dec.rs1    = insn[19:15];
    dec.rs2    = insn[24:20];
    legal      = 1'b1;

    case (insn[6:0])
      OPC_OP:
        case ({funct7, funct3})
          10'b0000000_000: dec.alu_op = ALU_ADD;
          10'b0100000_000: dec.alu_op = ALU_SUB;
          10'b0000000_001: dec.alu_op = ALU_SLL;
          10'b0000000_010: dec.alu_op = ALU_SLT;
          10'b0000000_011: dec.alu_op = ALU_SLTU;
          10'b0000000_100: dec.alu_op = ALU_XOR;
          10'b0000000_101: dec.alu_op = ALU_SRL;
          10'b0100000_101: dec.alu_op = ALU_SRA;
          10'b0000000_110: dec.alu_op = ALU_OR;
          10'b0000000_111: dec.alu_op = ALU_AND;
          default:         legal      = 1'b0;
        endcase
      OPC_OP_IMM:
      begin
        dec.use_imm = 1'b1;
        dec.imm     = {{20{insn[31]}}, insn[31:20]};
        case (funct3)
          3'b000: dec.alu_op = ALU_ADD;
          3'b010: dec.alu_op = ALU_SLT;
          3'b011: dec.alu_op = ALU_SLTU;
          3'b100: dec.alu_op = ALU_XOR;
          3'b110: dec.alu_op = ALU_OR;
          3'b111: dec.alu_op = ALU_AND;
          3'b001:
            if (funct7 == 7'b0000000)
              dec.alu_op = ALU_SLL;
            else
              legal = 1'b0;
          3'b101:
            if (funct7 == 7'b0000000)
              dec.alu_op = ALU_SRL;
            else if (funct7 == 7'b0100000)
              dec.alu_op = ALU_SRA;
            else
              legal = 1'b0;
        endcase
      end
      OPC_LUI:
      begin
        dec.alu_op  = ALU_PASS_B;
        dec.use_imm = 1'b1;
        dec.imm     = {insn[31:12], 12'h000};
      end
      default: legal = 1'b0;    // Retires as no-op
    endcase

    dec.rd_we = legal && (dec.rd != '0);
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      valid_q <= 1'b0;
    else
      valid_q <= if_valid_i;
  end

  // Producer two ahead sits in the write-back slot now
  always_ff @(posedge clk_i)
  begin
    dec_q  <= dec;
    op_a_q <= fwd(rs1_idx_o, rf_rs1_i, wb_valid_i, wb_we_i, wb_rd_i, wb_result_i);
    op_b_q <= fwd(rs2_idx_o, rf_rs2_i, wb_valid_i, wb_we_i, wb_rd_i, wb_result_i);
  end

  // Producer one ahead has just left execute, it wins
  assign id_valid_o = valid_q;
  assign id_dec_o   = dec_q;
  assign id_op_a_o  = fwd(dec_q.rs1, op_a_q, ex_valid_i, ex_we_i, ex_rd_i, ex_result_i);
  assign id_op_b_o  = fwd(dec_q.rs2, op_b_q, ex_valid_i, ex_we_i, ex_rd_i, ex_result_i);

  a_no_x0_we: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    id_valid_o && id_dec_o.rd_we |-> id_dec_o.rd != '0);

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
  import core_pkg::*;
#(
  parameter word_t PC_INIT = 'h200
)
(
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  input  wire logic du_stall_i,

  output word_t     imem_adr_o,
  output logic      imem_req_o,
  input  wire logic imem_ack_i,
  input  wire word_t imem_insn_i,

  output logic      if_valid_o,
  output word_t     if_pc_o,
  output word_t     if_insn_o,
  output word_t     pc_o
);

  word_t pc_q;     // Next fetch address
  logic  pend_q;   // Request out, no ack yet
  logic  valid_q;
  word_t insn_q;
  word_t ipc_q;
  logic  take;

  // A waiting request stays up even when a stall arrives
  assign imem_req_o = pend_q || !du_stall_i;
  assign imem_adr_o = pc_q;
  assign take       = imem_req_o && imem_ack_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      pc_q    <= PC_INIT;
      pend_q  <= 1'b0;
      valid_q <= 1'b0;
    end
    else
    begin
      if (take)
        pc_q <= pc_q + word_t'(4);  // No branches, always sequential
      pend_q  <= imem_req_o && !imem_ack_i;
      valid_q <= take;               // Missing ack leaves a bubble
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      insn_q <= imem_insn_i;
      ipc_q  <= pc_q;
    end
  end

  assign if_valid_o = valid_q;
  assign if_pc_o    = ipc_q;
  assign if_insn_o  = insn_q;
  assign pc_o       = pc_q;

  // Address held until the memory answers
  a_adr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    imem_req_o && !imem_ack_i |=> imem_req_o && $stable(imem_adr_o));

endmodule

`default_nettype wire

//--- common/rf_dbg_if.sv
`timescale 1ns/1ps
`default_nettype none

// Debug side access to the integer register file
interface rf_dbg_if
  import core_pkg::*;
();

  reg_idx_t addr;
  logic     we;      // Write at the clock edge
  word_t    wdata;
  word_t    rdata;   // Combinational read

  modport du (
    output addr,
    output we,
    output wdata,
    input  rdata
  );

  modport rf (
    input  addr,
    input  we,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

//--- common/core_pkg.sv
`default_nettype none

package core_pkg;

  ////////////////////////////////////////
  // Widths and basic types
  ////////////////////////////////////////
  localparam int XLEN          = 32;
  localparam int DBG_ADDR_SIZE = 6;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  // Debug map: 0..31 are x0..x31
  localparam logic [DBG_ADDR_SIZE-1:0] DBG_PC_ADDR = 6'd32;

  localparam word_t NOP_INSN = 32'h0000_0013;  // ADDI x0,x0,0

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // LUI
  } alu_op_e;

  typedef struct packed {
    alu_op_e  alu_op;
    reg_idx_t rd;
    logic     rd_we;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     use_imm;   // Operand B from imm
    word_t    imm;
  } decoded_t;

endpackage

`default_nettype wire
